// File: verilog/dist_consts.svh
`ifndef DIST_CONSTS_SVH
`define DIST_CONSTS_SVH

////////////////////
// distribution network sizes
////////////////////

// payload bits carried by one beat
`define DIST_DATA_W 32

// leaves of the tree, fixed at four
`define DIST_LEAVES 4

// one switch command: bit 1 high branch, bit 0 low branch
`define DIST_CMD_W 2

// per-leaf delivered-word counter, saturates at all ones
`define DIST_CNT_W 8

`endif

// File: verilog/dist_cfg_pkg.sv
package dist_cfg_pkg;

	`include "dist_consts.svh"

	////////////////////
	// switch commands
	////////////////////

	// bit 1 selects the high branch, bit 0 the low branch
	typedef enum logic [`DIST_CMD_W-1:0] {
		CMD_NONE = 2'b00,
		CMD_LOW  = 2'b01,
		CMD_HIGH = 2'b10,
		CMD_DUP  = 2'b11
	} dist_cmd_e;

	// how the configuration body is read
	typedef enum logic {
		MODE_DIRECT = 1'b0,
		MODE_MASK   = 1'b1
	} dist_mode_e;

	////////////////////
	// configuration word
	////////////////////

	// explicit command per switch
	typedef struct packed {
		dist_cmd_e root;
		// hi sub-switch drives leaves 3 and 2
		dist_cmd_e hi;
		// lo sub-switch drives leaves 1 and 0
		dist_cmd_e lo;
	} dist_cfg_direct_s;

	// destination mask, bit n selects leaf n
	typedef struct packed {
		// unused, fills out to three commands
		logic [3*`DIST_CMD_W-`DIST_LEAVES-1:0] pad;
		logic [`DIST_LEAVES-1:0]               mask;
	} dist_cfg_mask_s;

	// same six bits, two readings
	typedef union packed {
		dist_cfg_direct_s direct;
		dist_cfg_mask_s   masked;
	} dist_cfg_u;

	typedef struct packed {
		dist_mode_e mode;
		dist_cfg_u  body;
	} dist_cfg_s;

	// decoded commands, one per switch
	typedef struct packed {
		dist_cmd_e root;
		dist_cmd_e hi;
		dist_cmd_e lo;
	} dist_sw_cmd_s;

endpackage

// File: verilog/dist_data_pkg.sv
package dist_data_pkg;

	`include "dist_consts.svh"

	////////////////////
	// data path types
	////////////////////

	// one word on a link, data is zero when not valid
	typedef struct packed {
		logic                    valid;
		logic [`DIST_DATA_W-1:0] data;
	} dist_beat_s;

	// both branches of a 1x2 switch
	typedef struct packed {
		dist_beat_s hi;
		dist_beat_s lo;
	} dist_pair_s;

	// one beat per leaf, index is the leaf number
	typedef dist_beat_s [`DIST_LEAVES-1:0] dist_leaf_vec_s;

endpackage

// File: verilog/dist_cfg_decode.sv
`timescale 1ns/1ps

module dist_cfg_decode (
	input  logic                        clk,
	input  logic                        rst,
	// one-cycle load strobe, independent of the enable
	input  logic                        i_cfg_load,
	input  dist_cfg_pkg::dist_cfg_s     i_cfg,
	// registered commands, one per switch
	output dist_cfg_pkg::dist_sw_cmd_s  o_cmd
);
	import dist_cfg_pkg::*;

	// commands decoded from the incoming word
	dist_sw_cmd_s cmd_d;
	// mask view of the incoming word
	logic [3:0]   mask;

	assign mask = i_cfg.body.masked.mask;

	////////////////////
	// decode
	////////////////////

	always_comb
	begin
		if (i_cfg.mode == MODE_MASK)
		begin
			// root high if any upper leaf wanted
			// root low if any lower leaf wanted
			cmd_d.root = dist_cmd_e'({mask[3] | mask[2], mask[1] | mask[0]});
			// leaf 3 on hi branch, leaf 2 on lo branch
			cmd_d.hi   = dist_cmd_e'(mask[3:2]);
			// leaf 1 on hi branch, leaf 0 on lo branch
			cmd_d.lo   = dist_cmd_e'(mask[1:0]);
		end
		else
		begin
			// direct view, fields straight through
			cmd_d.root = i_cfg.body.direct.root;
			cmd_d.hi   = i_cfg.body.direct.hi;
			cmd_d.lo   = i_cfg.body.direct.lo;
		end
	end

	////////////////////
	// command register
	////////////////////

	// new commands active after the load edge
	// held until the next load
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// nothing routed until configured
			o_cmd.root <= CMD_NONE;
			o_cmd.hi   <= CMD_NONE;
			o_cmd.lo   <= CMD_NONE;
		end
		else if (i_cfg_load)
		begin
			o_cmd <= cmd_d;
		end
	end

endmodule

// File: verilog/distribute_1x2_seq.sv
`timescale 1ns/1ps
`include "dist_consts.svh"

module distribute_1x2_seq #(
	parameter int DATA_W = `DIST_DATA_W
)(
	input  logic                       clk,
	input  logic                       rst,
	// level enable, stage holds while low
	input  logic                       i_en,
	input  dist_data_pkg::dist_beat_s  i_beat,
	input  dist_cfg_pkg::dist_cmd_e    i_cmd,
	// registered branches
	output dist_data_pkg::dist_pair_s  o_pair
);
	import dist_cfg_pkg::*;
	import dist_data_pkg::*;

	// branch selects
	logic              sel_hi;
	logic              sel_lo;
	// payload per branch, zeroed when not selected
	logic [DATA_W-1:0] data_hi;
	logic [DATA_W-1:0] data_lo;
	// next value of the output pair
	dist_pair_s        pair_d;

	////////////////////
	// routing
	////////////////////

	// none drops the beat, dup sends it both ways
	always_comb
	begin
		sel_hi = i_beat.valid && (i_cmd inside {CMD_HIGH, CMD_DUP});
		sel_lo = i_beat.valid && (i_cmd inside {CMD_LOW, CMD_DUP});
	end

	always_comb
	begin
		data_hi = sel_hi ? i_beat.data : '0;
		data_lo = sel_lo ? i_beat.data : '0;
		pair_d.hi.valid = sel_hi;
		pair_d.hi.data  = data_hi;
		pair_d.lo.valid = sel_lo;
		pair_d.lo.data  = data_lo;
	end

	////////////////////
	// output stage
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			o_pair <= '0;
		else if (i_en)
			o_pair <= pair_d;
	end

endmodule

// File: verilog/distribute_tree_1x4.sv
`timescale 1ns/1ps
`include "dist_consts.svh"

module distribute_tree_1x4 (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           i_en,
	input  dist_data_pkg::dist_beat_s      i_beat,
	input  dist_cfg_pkg::dist_sw_cmd_s     i_cmd,
	// leaf beats, two stages after the input
	output dist_data_pkg::dist_leaf_vec_s  o_leaf
);
	import dist_cfg_pkg::*;
	import dist_data_pkg::*;

	// root output, feeds the two sub-switches
	dist_pair_s root_pair;
	// sub-switch outputs
	dist_pair_s hi_pair;
	dist_pair_s lo_pair;
	// sub-switch commands, one stage behind the root
	dist_cmd_e  hi_cmd_q;
	dist_cmd_e  lo_cmd_q;

	////////////////////
	// command alignment
	////////////////////

	// follows the beat through the root stage
	// so a reload never splits a beat's route
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hi_cmd_q <= CMD_NONE;
			lo_cmd_q <= CMD_NONE;
		end
		else if (i_en)
		begin
			hi_cmd_q <= i_cmd.hi;
			lo_cmd_q <= i_cmd.lo;
		end
	end

	////////////////////
	// switches
	////////////////////

	// level 0
	distribute_1x2_seq #(.DATA_W(`DIST_DATA_W)) i_root_sw (
		.clk(clk), .rst(rst), .i_en(i_en),
		.i_beat(i_beat), .i_cmd(i_cmd.root), .o_pair(root_pair)
	);

	// level 1, upper half of the leaves
	distribute_1x2_seq #(.DATA_W(`DIST_DATA_W)) i_hi_sw (
		.clk(clk), .rst(rst), .i_en(i_en),
		.i_beat(root_pair.hi), .i_cmd(hi_cmd_q), .o_pair(hi_pair)
	);

	// level 1, lower half of the leaves
	distribute_1x2_seq #(.DATA_W(`DIST_DATA_W)) i_lo_sw (
		.clk(clk), .rst(rst), .i_en(i_en),
		.i_beat(root_pair.lo), .i_cmd(lo_cmd_q), .o_pair(lo_pair)
	);

	// high branch is the odd leaf
	assign o_leaf[3] = hi_pair.hi;
	assign o_leaf[2] = hi_pair.lo;
	assign o_leaf[1] = lo_pair.hi;
	assign o_leaf[0] = lo_pair.lo;

endmodule

// File: verilog/dist_leaf_collect.sv
`timescale 1ns/1ps
`include "dist_consts.svh"

module dist_leaf_collect (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     i_en,
	input  dist_data_pkg::dist_leaf_vec_s            i_leaf,
	// registered leaf beats
	output dist_data_pkg::dist_leaf_vec_s            o_leaf,
	// delivered words per leaf
	output logic [`DIST_LEAVES-1:0][`DIST_CNT_W-1:0] o_count
);
	// counter ceiling
	localparam logic [`DIST_CNT_W-1:0] CNT_MAX = '1;

	// leaves whose counter steps this edge
	logic [`DIST_LEAVES-1:0] bump;

	////////////////////
	// count enables
	////////////////////

	// a valid beat entering the output register
	// counts unless already at the ceiling
	always_comb
	begin
		for (int n = 0; n < `DIST_LEAVES; n++)
			bump[n] = i_leaf[n].valid && (o_count[n] != CNT_MAX);
	end

	////////////////////
	// output stage
	////////////////////

	// count moves on the same edge the beat lands on o_leaf
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_leaf  <= '0;
			o_count <= '0;
		end
		else if (i_en)
		begin
			o_leaf <= i_leaf;
			for (int n = 0; n < `DIST_LEAVES; n++)
			begin
				if (bump[n])
					o_count[n] <= o_count[n] + 1'b1;
			end
		end
	end

endmodule

// File: verilog/dist_net_top.sv
`timescale 1ns/1ps
`include "dist_consts.svh"

module dist_net_top (
	input  logic                                     clk,
	input  logic                                     rst,
	// configuration load
	input  logic                                     i_cfg_load,
	input  dist_cfg_pkg::dist_cfg_s                  i_cfg,
	// global stage enable
	input  logic                                     i_en,
	input  dist_data_pkg::dist_beat_s                i_beat,
	// leaf outputs and delivered counts
	output dist_data_pkg::dist_leaf_vec_s            o_leaf,
	output logic [`DIST_LEAVES-1:0][`DIST_CNT_W-1:0] o_count
);
	import dist_cfg_pkg::*;
	import dist_data_pkg::*;

	// decoded commands into the tree
	dist_sw_cmd_s   cmd;
	// tree leaves into the collector
	dist_leaf_vec_s leaf;

	// decode stage
	dist_cfg_decode i_decode (
		.clk(clk), .rst(rst),
		.i_cfg_load(i_cfg_load), .i_cfg(i_cfg),
		.o_cmd(cmd)
	);

	// execute, two switch levels
	distribute_tree_1x4 i_tree (
		.clk(clk), .rst(rst), .i_en(i_en),
		.i_beat(i_beat), .i_cmd(cmd),
		.o_leaf(leaf)
	);

	// result, third pipeline stage
	dist_leaf_collect i_collect (
		.clk(clk), .rst(rst), .i_en(i_en),
		.i_leaf(leaf),
		.o_leaf(o_leaf), .o_count(o_count)
	);

endmodule

// File: verification/dist_net_assert.sv
`timescale 1ns/1ps
`include "dist_consts.svh"

module dist_net_assert (
	input logic                                     clk,
	input logic                                     rst,
	input logic                                     i_en,
	input dist_data_pkg::dist_leaf_vec_s            i_leaf,
	input logic [`DIST_LEAVES-1:0][`DIST_CNT_W-1:0] i_count
);
	// leaf valids as one vector
	logic [`DIST_LEAVES-1:0] leaf_valid;

	always_comb
	begin
		for (int n = 0; n < `DIST_LEAVES; n++)
			leaf_valid[n] = i_leaf[n].valid;
	end

	////////////////////
	// leaf data
	////////////////////

	// an idle leaf carries zero data
	for (genvar n = 0; n < `DIST_LEAVES; n++)
	begin : g_idle_zero
		a_idle_zero : assert property (@(posedge clk) disable iff (rst)
			!i_leaf[n].valid |-> i_leaf[n].data == '0)
			else $error("leaf %0d carries data while idle", n);
	end

	////////////////////
	// enable and reset
	////////////////////

	// enable low at an edge, so nothing moves across it
	a_hold : assert property (@(posedge clk)
		(!i_en && !rst) |=> ($stable(i_leaf) && $stable(i_count)))
		else $error("leaf outputs or counts moved with the enable low");

	// pipeline empty for two edges after release
	a_quiet_after_rst : assert property (@(posedge clk)
		(!rst && ($past(rst) || $past(rst, 2))) |-> leaf_valid == '0)
		else $error("leaf valid right after reset release");

endmodule

// File: verification/dist_net_tb.sv
`timescale 1ns/1ps
`include "dist_consts.svh"

module dist_net_tb;
	import dist_cfg_pkg::*;
	import dist_data_pkg::*;

	logic                                     clk;
	logic                                     rst;
	logic                                     cfg_load;
	dist_cfg_s                                cfg;
	logic                                     en;
	dist_beat_s                               beat;
	dist_leaf_vec_s                           leaf;
	logic [`DIST_LEAVES-1:0][`DIST_CNT_W-1:0] count;

	// model state for the leaf set, the three stages and the counts
	logic [`DIST_LEAVES-1:0]                  m_set;
	dist_leaf_vec_s                           m_pipe [3];
	logic [`DIST_LEAVES-1:0][`DIST_CNT_W-1:0] m_cnt;
	// enable seen at the last edge
	logic                                     last_en;
	logic [`DIST_DATA_W-1:0]                  sent [$];
	logic [`DIST_DATA_W-1:0]                  got [$];

	dist_net_top i_dut (
		.clk(clk), .rst(rst), .i_cfg_load(cfg_load), .i_cfg(cfg),
		.i_en(en), .i_beat(beat), .o_leaf(leaf), .o_count(count)
	);

	bind dist_net_top dist_net_assert i_assert (
		.clk(clk), .rst(rst), .i_en(i_en), .i_leaf(o_leaf), .i_count(o_count)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	////////////////////
	// model rules
	////////////////////

	function automatic logic takes_high(input dist_cmd_e c);
		return (c == CMD_HIGH) || (c == CMD_DUP);
	endfunction

	function automatic logic takes_low(input dist_cmd_e c);
		return (c == CMD_LOW) || (c == CMD_DUP);
	endfunction

	// hi switch owns leaves 3 and 2 and lo switch leaves 1 and 0
	function automatic logic [3:0] direct_leaves(input dist_cmd_e r, input dist_cmd_e h,
		input dist_cmd_e l);
		logic [3:0] s;
		s[3] = takes_high(r) && takes_high(h);
		s[2] = takes_high(r) && takes_low(h);
		s[1] = takes_low(r) && takes_high(l);
		s[0] = takes_low(r) && takes_low(l);
		return s;
	endfunction

	// mask mode reaches exactly the mask
	function automatic logic [3:0] cfg_leaves(input dist_cfg_s c);
		if (c.mode == MODE_MASK)
			return c.body.masked.mask;
		return direct_leaves(c.body.direct.root, c.body.direct.hi, c.body.direct.lo);
	endfunction

	function automatic dist_leaf_vec_s spread(input dist_beat_s b, input logic [3:0] s);
		dist_leaf_vec_s v;
		for (int n = 0; n < `DIST_LEAVES; n++)
		begin
			v[n].valid = b.valid && s[n];
			v[n].data  = v[n].valid ? b.data : '0;
		end
		return v;
	endfunction

	function automatic dist_cfg_s direct_cfg(input dist_cmd_e r, input dist_cmd_e h,
		input dist_cmd_e l);
		dist_cfg_s c;
		c.mode             = MODE_DIRECT;
		c.body.direct.root = r;
		c.body.direct.hi   = h;
		c.body.direct.lo   = l;
		return c;
	endfunction

	function automatic dist_cfg_s mask_cfg(input logic [3:0] m);
		dist_cfg_s c;
		c.mode             = MODE_MASK;
		// pad bits are don't care
		c.body.masked.pad  = 2'($urandom());
		c.body.masked.mask = m;
		return c;
	endfunction

	function automatic logic [3:0] leaf_valids();
		logic [3:0] v;
		for (int n = 0; n < `DIST_LEAVES; n++)
			v[n] = leaf[n].valid;
		return v;
	endfunction

	////////////////////
	// stepping and checks
	////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	// one edge with the model stepped and the outputs compared
	task automatic tick();
		@(posedge clk);
		last_en = en;
		if (rst)
		begin
			m_pipe[0] = '0;
			m_pipe[1] = '0;
			m_pipe[2] = '0;
			m_cnt     = '0;
			m_set     = '0;
		end
		else
		begin
			if (en)
			begin
				// o_leaf is the last of three stages
				m_pipe[2] = m_pipe[1];
				m_pipe[1] = m_pipe[0];
				m_pipe[0] = spread(beat, m_set);
				for (int n = 0; n < `DIST_LEAVES; n++)
				begin
					if (m_pipe[2][n].valid && m_cnt[n] != '1)
						m_cnt[n] = m_cnt[n] + 8'd1;
				end
			end
			// load applies from the next sampled beat even with the enable low
			if (cfg_load)
				m_set = cfg_leaves(cfg);
		end
		#1;
		assert (leaf === m_pipe[2])
		else abort_run($sformatf("ERR o_leaf got %h exp %h", leaf, m_pipe[2]));
		assert (count === m_cnt)
		else abort_run($sformatf("ERR o_count got %h exp %h", count, m_cnt));
	endtask

	task automatic load_cfg(input dist_cfg_s c);
		cfg      = c;
		cfg_load = 1'b1;
		tick();
		cfg_load = 1'b0;
	endtask

	task automatic wait_leaf_valid(input int limit, output int waited);
		waited = 0;
		while (leaf_valids() == '0)
		begin
			if (waited >= limit)
				abort_run("timed out waiting for a leaf valid");
			else
			begin
				tick();
				waited++;
			end
		end
	endtask

	// single beat checked for route and two-edge latency
	task automatic send_and_expect(input logic [`DIST_DATA_W-1:0] d, input logic [3:0] exp);
		int waited;
		beat.valid = 1'b1;
		beat.data  = d;
		tick();
		beat = '0;
		if (exp == '0)
		begin
			repeat (3) tick();
			assert (leaf_valids() == '0)
			else abort_run($sformatf("ERR o_leaf valid got %h exp %h", leaf_valids(), 4'h0));
		end
		else
		begin
			wait_leaf_valid(8, waited);
			assert (waited == 2)
			else abort_run($sformatf("ERR latency got %h exp %h", waited, 2));
			assert (leaf_valids() == exp)
			else abort_run($sformatf("ERR o_leaf valid got %h exp %h", leaf_valids(), exp));
			tick();
		end
	endtask

	task automatic step_collect();
		tick();
		if (last_en && leaf[0].valid)
			got.push_back(leaf[0].data);
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic reset_and_idle();
		rst = 1'b1;
		repeat (10) tick();
		rst = 1'b0;
		assert (leaf_valids() == '0)
		else abort_run($sformatf("ERR o_leaf valid got %h exp %h", leaf_valids(), 4'h0));
		assert (count == '0)
		else abort_run($sformatf("ERR o_count got %h exp %h", count, 32'h0));
		// no configuration loaded yet
		send_and_expect($urandom(), 4'b0000);
	endtask

	task automatic direct_routes();
		for (int r = 0; r < 4; r++)
			for (int h = 0; h < 4; h++)
				for (int l = 0; l < 4; l++)
				begin
					load_cfg(direct_cfg(dist_cmd_e'(r[1:0]), dist_cmd_e'(h[1:0]),
						dist_cmd_e'(l[1:0])));
					send_and_expect($urandom(), direct_leaves(dist_cmd_e'(r[1:0]),
						dist_cmd_e'(h[1:0]), dist_cmd_e'(l[1:0])));
				end
		// up then down lands on leaf 2
		load_cfg(direct_cfg(CMD_HIGH, CMD_LOW, CMD_NONE));
		send_and_expect($urandom(), 4'b0100);
	endtask

	task automatic mask_multicast();
		logic [3:0] m;
		repeat (24)
		begin
			m = 4'($urandom_range(15, 1));
			load_cfg(mask_cfg(m));
			send_and_expect($urandom(), m);
		end
		// broadcast
		load_cfg(mask_cfg(4'hf));
		send_and_expect($urandom(), 4'hf);
	endtask

	task automatic reload_between_beats();
		logic [`DIST_DATA_W-1:0] pay [4];
		logic [3:0]              exp_set [4];
		load_cfg(direct_cfg(CMD_LOW, CMD_NONE, CMD_DUP));
		exp_set[0] = 4'b0011;
		exp_set[1] = 4'b1000;
		exp_set[2] = 4'b1100;
		exp_set[3] = 4'b1100;
		for (int i = 0; i < 6; i++)
		begin
			beat     = '0;
			cfg_load = 1'b0;
			if (i < 4)
			begin
				pay[i]     = $urandom();
				beat.valid = 1'b1;
				beat.data  = pay[i];
			end
			// reloads ride along with beats 0 and 1
			if (i == 0)
			begin
				cfg      = mask_cfg(4'b1000);
				cfg_load = 1'b1;
			end
			if (i == 1)
			begin
				cfg      = direct_cfg(CMD_HIGH, CMD_DUP, CMD_NONE);
				cfg_load = 1'b1;
			end
			tick();
			if (i >= 2)
			begin
				assert (leaf_valids() == exp_set[i-2])
				else abort_run($sformatf("ERR o_leaf valid got %h exp %h",
					leaf_valids(), exp_set[i-2]));
				for (int n = 0; n < `DIST_LEAVES; n++)
					if (exp_set[i-2][n])
						assert (leaf[n].data === pay[i-2])
						else abort_run($sformatf("ERR o_leaf[%0d].data got %h exp %h",
							n, leaf[n].data, pay[i-2]));
			end
		end
	endtask

	// enable low for a few edges while nothing moves
	task automatic freeze_for(input int cycles);
		dist_leaf_vec_s                           snap_leaf;
		logic [`DIST_LEAVES-1:0][`DIST_CNT_W-1:0] snap_count;
		snap_leaf  = leaf;
		snap_count = count;
		en = 1'b0;
		repeat (cycles)
		begin
			step_collect();
			assert (leaf === snap_leaf)
			else abort_run($sformatf("ERR o_leaf got %h exp %h", leaf, snap_leaf));
			assert (count === snap_count)
			else abort_run($sformatf("ERR o_count got %h exp %h", count, snap_count));
		end
		en = 1'b1;
	endtask

	task automatic enable_pause();
		logic [`DIST_DATA_W-1:0] d;
		int                      waited;
		load_cfg(mask_cfg(4'b0101));
		sent.delete();
		got.delete();
		for (int i = 0; i < 8; i++)
		begin
			d = $urandom();
			sent.push_back(d);
			beat.valid = 1'b1;
			beat.data  = d;
			// beat 3 waits at the input through the pause
			if (i == 3)
				freeze_for(4);
			step_collect();
		end
		beat   = '0;
		waited = 0;
		while (got.size() < sent.size())
		begin
			if (waited >= 10)
				abort_run("stream did not drain after the enable came back");
			else
			begin
				step_collect();
				waited++;
			end
		end
		for (int i = 0; i < sent.size(); i++)
			assert (got[i] === sent[i])
			else abort_run($sformatf("ERR o_leaf[0].data got %h exp %h", got[i], sent[i]));
	endtask

	task automatic count_saturation();
		load_cfg(mask_cfg(4'b0001));
		send_and_expect($urandom(), 4'b0001);
		// well past the ceiling
		beat.valid = 1'b1;
		repeat (300)
		begin
			beat.data = $urandom();
			tick();
		end
		beat = '0;
		repeat (3) tick();
		assert (count[0] === 8'hff)
		else abort_run($sformatf("ERR o_count[0] got %h exp %h", count[0], 8'hff));
	endtask

	initial
	begin
		void'($urandom(91422));
		rst       = 1'b1;
		cfg_load  = 1'b0;
		cfg       = '0;
		en        = 1'b1;
		beat      = '0;
		last_en   = 1'b0;
		reset_and_idle();
		direct_routes();
		mask_multicast();
		reload_between_beats();
		enable_pause();
		count_saturation();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/dist_cfg_pkg.sv
verilog/dist_data_pkg.sv
verilog/dist_cfg_decode.sv
verilog/distribute_1x2_seq.sv
verilog/distribute_tree_1x4.sv
verilog/dist_leaf_collect.sv
verilog/dist_net_top.sv
verification/dist_net_assert.sv
verification/dist_net_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the distribution network testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f src.f --top-module dist_net_tb -Mdir "$BUILD_DIR" -o dist_net_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/dist_net_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
